// ==== hdl/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// integer register width
`define RV_XLEN 64

// x0 through x31
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

`endif

// ==== hdl/rv_isa_pkg.sv ====
`include "rv_macros.svh"

package rv_isa_pkg;

  // data and address word
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // register index, x0 to x31
  typedef logic [4:0] reg_addr_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // major opcodes, instr[6:0]
  // only the ones this core decodes
  typedef enum logic [6:0] {
    maj_lui    = 7'b0110111,
    maj_auipc  = 7'b0010111,
    maj_jal    = 7'b1101111,
    maj_jalr   = 7'b1100111,
    maj_op_imm = 7'b0010011,
    maj_system = 7'b1110011
  } major_op_t;

endpackage

// ==== hdl/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

  // operation handed from decode to execute
  typedef enum logic [2:0] {
    exec_nop,
    exec_lui,
    exec_auipc,
    exec_jal,
    exec_jalr,
    exec_addi,
    exec_ebreak,
    exec_illegal
  } exec_op_t;

  // core run state
  typedef enum logic {
    st_run,
    st_halted
  } run_state_t;

endpackage

// ==== hdl/rv_fetch.sv ====
`include "rv_macros.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                reset,
  input  rv_isa_pkg::xlen_t   dnpc,
  input  logic                halt_req,
  input  logic                halt_illegal,
  input  rv_isa_pkg::xlen_t   a0,
  output rv_isa_pkg::xlen_t   pc,
  output logic                halted,
  output logic                illegal,
  output rv_isa_pkg::xlen_t   exit_code
);

  rv_ctrl_pkg::run_state_t state;

  // pc and run/halt state
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= rv_ctrl_pkg::st_run;
      pc      <= `RV_RESET_PC;
      illegal <= 1'b0;
    end else begin
      case (state)
        rv_ctrl_pkg::st_run: begin
          if (halt_req) begin
            // pc stays on the halting instruction
            state   <= rv_ctrl_pkg::st_halted;
            illegal <= halt_illegal;
          end else begin
            pc <= dnpc;
          end
        end
        default: begin
          // frozen until reset
          state <= rv_ctrl_pkg::st_halted;
        end
      endcase
    end
  end

  // a0 as seen just before the halt edge
  always_ff @(posedge clk) begin
    if (state == rv_ctrl_pkg::st_run && halt_req) begin
      exit_code <= a0;
    end
  end

  assign halted = (state == rv_ctrl_pkg::st_halted);

endmodule

// ==== hdl/rv_decode.sv ====
`include "rv_macros.svh"

module rv_decode (
  input  rv_isa_pkg::inst_t       instr,
  output rv_ctrl_pkg::exec_op_t   op,
  output rv_isa_pkg::reg_addr_t   rd,
  output rv_isa_pkg::reg_addr_t   rs1,
  output rv_isa_pkg::xlen_t       imm_i,
  output rv_isa_pkg::xlen_t       imm_u,
  output rv_isa_pkg::xlen_t       imm_j
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;

  // instruction fields
  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct12 = instr[31:20];
  assign rd      = instr[11:7];
  assign rs1     = instr[19:15];

  // sign-extended immediates
  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  // J layout is scrambled, bit 0 is always zero
  assign imm_j = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  // opcode plus funct fields to one execute op
  always_comb begin
    op = rv_ctrl_pkg::exec_illegal;
    case (rv_isa_pkg::major_op_t'(opcode))
      rv_isa_pkg::maj_lui: begin
        op = rv_ctrl_pkg::exec_lui;
      end
      rv_isa_pkg::maj_auipc: begin
        op = rv_ctrl_pkg::exec_auipc;
      end
      rv_isa_pkg::maj_jal: begin
        op = rv_ctrl_pkg::exec_jal;
      end
      rv_isa_pkg::maj_jalr: begin
        if (funct3 == 3'b000) begin
          op = rv_ctrl_pkg::exec_jalr;
        end
      end
      rv_isa_pkg::maj_op_imm: begin
        // only addi among the op-imm group
        if (funct3 == 3'b000) begin
          op = rv_ctrl_pkg::exec_addi;
        end
      end
      rv_isa_pkg::maj_system: begin
        // ebreak has rd, rs1 and funct3 all zero
        if (funct3 == 3'b000 && funct12 == 12'h001 && rd == '0 && rs1 == '0) begin
          op = rv_ctrl_pkg::exec_ebreak;
        end
      end
      default: begin
        op = rv_ctrl_pkg::exec_illegal;
      end
    endcase
  end

endmodule

// ==== hdl/rv_regfile.sv ====
`include "rv_macros.svh"

module rv_regfile (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_isa_pkg::reg_addr_t   rs1,
  output rv_isa_pkg::xlen_t       src1,
  output rv_isa_pkg::xlen_t       a0,
  input  logic                    wen,
  input  rv_isa_pkg::reg_addr_t   waddr,
  input  rv_isa_pkg::xlen_t       wdata
);

  localparam int A0_INDEX = 10;

  rv_isa_pkg::xlen_t regs [`RV_REG_COUNT];

  // x0 is never written, so it reads zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads
  assign src1 = regs[rs1];
  // exit code source
  assign a0   = regs[A0_INDEX];

endmodule

// ==== hdl/rv_execute.sv ====
module rv_execute (
  input  rv_ctrl_pkg::exec_op_t   op,
  input  rv_isa_pkg::xlen_t       pc,
  input  rv_isa_pkg::reg_addr_t   rd,
  input  rv_isa_pkg::xlen_t       src1,
  input  rv_isa_pkg::xlen_t       imm_i,
  input  rv_isa_pkg::xlen_t       imm_u,
  input  rv_isa_pkg::xlen_t       imm_j,
  input  logic                    halted,
  output logic                    wen,
  output rv_isa_pkg::reg_addr_t   waddr,
  output rv_isa_pkg::xlen_t       wdata,
  output rv_isa_pkg::xlen_t       dnpc,
  output logic                    halt_req,
  output logic                    halt_illegal
);

  rv_ctrl_pkg::exec_op_t op_eff;
  rv_isa_pkg::xlen_t     add_a;
  rv_isa_pkg::xlen_t     add_b;
  rv_isa_pkg::xlen_t     sum;
  rv_isa_pkg::xlen_t     snpc;

  // once halted, behave as a nop
  assign op_eff = halted ? rv_ctrl_pkg::exec_nop : op;

  // shared adder operands
  always_comb begin
    add_a = src1;
    add_b = imm_i;
    case (op_eff)
      rv_ctrl_pkg::exec_auipc: begin
        add_a = pc;
        add_b = imm_u;
      end
      rv_ctrl_pkg::exec_jal: begin
        add_a = pc;
        add_b = imm_j;
      end
      default: begin
        // jalr and addi use src1 + imm_i
        add_a = src1;
        add_b = imm_i;
      end
    endcase
  end

  assign sum  = add_a + add_b;
  assign snpc = pc + 64'd4;

  // write-back and next pc
  always_comb begin
    wen   = 1'b0;
    wdata = sum;
    dnpc  = snpc;
    case (op_eff)
      rv_ctrl_pkg::exec_lui: begin
        wen   = 1'b1;
        wdata = imm_u;
      end
      rv_ctrl_pkg::exec_auipc, rv_ctrl_pkg::exec_addi: begin
        wen   = 1'b1;
        wdata = sum;
      end
      rv_ctrl_pkg::exec_jal: begin
        wen   = 1'b1;
        wdata = snpc;
        dnpc  = sum;
      end
      rv_ctrl_pkg::exec_jalr: begin
        wen   = 1'b1;
        wdata = snpc;
        dnpc  = {sum[63:1], 1'b0};
      end
      default: begin
        wen = 1'b0;
      end
    endcase
  end

  assign waddr = rd;

  assign halt_illegal = (op_eff == rv_ctrl_pkg::exec_illegal);
  assign halt_req     = halt_illegal || (op_eff == rv_ctrl_pkg::exec_ebreak);

endmodule

// ==== hdl/rv_core.sv ====
module rv_core (
  input  logic                    clk,
  input  logic                    reset,
  output rv_isa_pkg::xlen_t       pc,
  input  rv_isa_pkg::inst_t       instr,
  output logic                    retire_valid,
  output rv_isa_pkg::reg_addr_t   retire_rd,
  output rv_isa_pkg::xlen_t       retire_data,
  output logic                    halted,
  output logic                    illegal,
  output rv_isa_pkg::xlen_t       exit_code
);

  rv_ctrl_pkg::exec_op_t   dec_op;
  rv_isa_pkg::reg_addr_t   dec_rd;
  rv_isa_pkg::reg_addr_t   dec_rs1;
  rv_isa_pkg::xlen_t       dec_imm_i;
  rv_isa_pkg::xlen_t       dec_imm_u;
  rv_isa_pkg::xlen_t       dec_imm_j;
  rv_isa_pkg::xlen_t       src1;
  rv_isa_pkg::xlen_t       a0;
  logic                    ex_wen;
  rv_isa_pkg::reg_addr_t   ex_waddr;
  rv_isa_pkg::xlen_t       ex_wdata;
  rv_isa_pkg::xlen_t       dnpc;
  logic                    halt_req;
  logic                    halt_illegal;

  rv_fetch u_fetch (
    .clk          (clk),
    .reset        (reset),
    .dnpc         (dnpc),
    .halt_req     (halt_req),
    .halt_illegal (halt_illegal),
    .a0           (a0),
    .pc           (pc),
    .halted       (halted),
    .illegal      (illegal),
    .exit_code    (exit_code)
  );

  rv_decode u_decode (
    .instr (instr),
    .op    (dec_op),
    .rd    (dec_rd),
    .rs1   (dec_rs1),
    .imm_i (dec_imm_i),
    .imm_u (dec_imm_u),
    .imm_j (dec_imm_j)
  );

  rv_regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .rs1   (dec_rs1),
    .src1  (src1),
    .a0    (a0),
    .wen   (ex_wen),
    .waddr (ex_waddr),
    .wdata (ex_wdata)
  );

  rv_execute u_execute (
    .op           (dec_op),
    .pc           (pc),
    .rd           (dec_rd),
    .src1         (src1),
    .imm_i        (dec_imm_i),
    .imm_u        (dec_imm_u),
    .imm_j        (dec_imm_j),
    .halted       (halted),
    .wen          (ex_wen),
    .waddr        (ex_waddr),
    .wdata        (ex_wdata),
    .dnpc         (dnpc),
    .halt_req     (halt_req),
    .halt_illegal (halt_illegal)
  );

  // commit trace, same x0 filter as the register file
  assign retire_valid = ex_wen && (ex_waddr != '0);
  assign retire_rd    = ex_waddr;
  assign retire_data  = ex_wdata;

endmodule

// ==== tb/rv_core_assertions.sv ====
`include "rv_macros.svh"

module rv_core_assertions (
  input logic                  clk,
  input logic                  reset,
  input rv_isa_pkg::xlen_t     pc,
  input rv_isa_pkg::inst_t     instr,
  input logic                  halted,
  input logic                  retire_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // a halted core keeps its pc until reset
  pc_frozen: assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
    else $error("pc changed while the core was halted");

  // rd field of the instruction being executed
  no_x0_retire: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> instr[11:7] != 5'd0)
    else $error("retire reported for x0");

  quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !retire_valid)
    else $error("retire reported while halted");

  pc_after_reset: assert property (@(posedge clk) reset |=> pc == `RV_RESET_PC)
    else $error("pc not at the reset address after reset");

endmodule

// ==== tb/rv_core_tb.sv ====
`include "rv_macros.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 20;
  localparam int clk_period = 2 * half_period;
  // cycles per test with reset: lui/addi, auipc/jal, jalr, two ebreaks, random, illegal
  localparam int test_cycles = 6 + 5 + 6 + 18 + 23 + 8;
  // addi x0,x0,0 while reset is high
  localparam rv_isa_pkg::inst_t nop_instr = 32'h0000_0013;

  logic                  clk = 1'b0;
  logic                  reset;
  rv_isa_pkg::xlen_t     pc;
  rv_isa_pkg::inst_t     instr;
  logic                  retire_valid;
  rv_isa_pkg::reg_addr_t retire_rd;
  rv_isa_pkg::xlen_t     retire_data;
  logic                  halted;
  logic                  illegal;
  rv_isa_pkg::xlen_t     exit_code;

  rv_isa_pkg::inst_t     rom [64];
  rv_isa_pkg::xlen_t     pc_offset;
  logic [5:0]            rom_index;
  rv_isa_pkg::xlen_t     shadow [32];
  logic [15:0]           lfsr;

  always #half_period clk = ~clk;

  // instruction ROM answers in the same cycle
  assign pc_offset = pc - `RV_RESET_PC;
  assign rom_index = pc_offset[7:2];
  assign instr = reset ? nop_instr : rom[rom_index];

  rv_core u_rv_core (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted),
    .illegal      (illegal),
    .exit_code    (exit_code)
  );

  bind rv_core rv_core_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instr        (instr),
    .halted       (halted),
    .retire_valid (retire_valid)
  );

  function automatic rv_isa_pkg::inst_t enc_i(input logic [6:0] opc,
      input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::reg_addr_t rs1,
      input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_u(input logic [6:0] opc,
      input rv_isa_pkg::reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // jal, offset bit 0 is dropped
  function automatic rv_isa_pkg::inst_t enc_jal(input rv_isa_pkg::reg_addr_t rd,
      input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::maj_jal};
  endfunction

  function automatic rv_isa_pkg::xlen_t sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic rv_isa_pkg::xlen_t sext_u(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [11:0] v);
    v = 12'h000;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[10:0], lfsr[0]};
    end
  endtask

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string what, input rv_isa_pkg::xlen_t got,
      input rv_isa_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_reg(input string what, input rv_isa_pkg::reg_addr_t got,
      input rv_isa_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // unused slots hold opcode zero and decode as illegal
  task automatic begin_reset();
    reset = 1'b1;
    for (int i = 0; i < 64; i++) begin
      rom[i] = {i[24:0], 7'b0000000};
    end
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
  endtask

  task automatic end_reset();
    repeat (3) step();
    reset = 1'b0;
    // instr switches from the reset nop to rom[0]
    #1;
  endtask

  task automatic expect_retire(input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::xlen_t data);
    check_bit("retire_valid", retire_valid, 1'b1);
    check_reg("retire_rd", retire_rd, rd);
    check_data("retire_data", retire_data, data);
    shadow[rd] = data;
  endtask

  task automatic check_addi(input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::reg_addr_t rs1,
      input logic [11:0] imm);
    if (rd == 5'd0) begin
      check_bit("retire_valid", retire_valid, 1'b0);
    end else begin
      expect_retire(rd, shadow[rs1] + sext12(imm));
    end
  endtask

  task automatic test_lui_addi();
    begin_reset();
    rom[0] = enc_u(rv_isa_pkg::maj_lui, 5'd5, 20'habcde);
    rom[1] = enc_i(rv_isa_pkg::maj_op_imm, 5'd5, 5'd5, 12'h800);
    rom[2] = enc_i(rv_isa_pkg::maj_op_imm, 5'd0, 5'd0, 12'h005);
    end_reset();
    check_data("pc", pc, `RV_RESET_PC);
    expect_retire(5'd5, sext_u(20'habcde));
    step();
    check_data("pc", pc, `RV_RESET_PC + 64'd4);
    check_addi(5'd5, 5'd5, 12'h800);
    step();
    check_data("pc", pc, `RV_RESET_PC + 64'd8);
    check_addi(5'd0, 5'd0, 12'h005);
    step();
    check_data("pc", pc, `RV_RESET_PC + 64'd12);
  endtask

  task automatic test_auipc_jal();
    begin_reset();
    rom[0] = enc_u(rv_isa_pkg::maj_auipc, 5'd6, 20'h00010);
    rom[1] = enc_jal(5'd1, 21'd16);
    rom[5] = enc_i(rv_isa_pkg::maj_op_imm, 5'd7, 5'd0, 12'h001);
    end_reset();
    expect_retire(5'd6, `RV_RESET_PC + sext_u(20'h00010));
    step();
    expect_retire(5'd1, `RV_RESET_PC + 64'd8);
    step();
    check_data("pc", pc, `RV_RESET_PC + 64'd4 + 64'd16);
    check_addi(5'd7, 5'd0, 12'h001);
  endtask

  task automatic test_jalr();
    rv_isa_pkg::xlen_t target;
    begin_reset();
    rom[0] = enc_u(rv_isa_pkg::maj_auipc, 5'd8, 20'h00000);
    rom[1] = enc_i(rv_isa_pkg::maj_op_imm, 5'd8, 5'd8, 12'h021);
    rom[2] = enc_i(rv_isa_pkg::maj_jalr, 5'd9, 5'd8, 12'h004);
    rom[9] = enc_i(rv_isa_pkg::maj_op_imm, 5'd11, 5'd0, 12'h7ff);
    end_reset();
    expect_retire(5'd8, `RV_RESET_PC);
    step();
    check_addi(5'd8, 5'd8, 12'h021);
    step();
    // odd sum, bit 0 must be cleared
    target = (shadow[8] + sext12(12'h004)) & ~64'd1;
    expect_retire(5'd9, `RV_RESET_PC + 64'd12);
    step();
    check_data("pc", pc, target);
    check_addi(5'd11, 5'd0, 12'h7ff);
  endtask

  task automatic ebreak_run(input logic [11:0] a0_imm);
    begin_reset();
    rom[0] = enc_i(rv_isa_pkg::maj_op_imm, 5'd10, 5'd0, a0_imm);
    rom[1] = enc_i(rv_isa_pkg::maj_system, 5'd0, 5'd0, 12'h001);
    end_reset();
    check_addi(5'd10, 5'd0, a0_imm);
    step();
    check_bit("halted", halted, 1'b0);
    check_bit("retire_valid", retire_valid, 1'b0);
    step();
    check_bit("halted", halted, 1'b1);
    check_bit("illegal", illegal, 1'b0);
    check_data("exit_code", exit_code, shadow[10]);
    for (int i = 0; i < 4; i++) begin
      check_data("pc", pc, `RV_RESET_PC + 64'd4);
      check_bit("retire_valid", retire_valid, 1'b0);
      check_bit("halted", halted, 1'b1);
      step();
    end
  endtask

  task automatic test_random_addi();
    rv_isa_pkg::reg_addr_t rds [20];
    rv_isa_pkg::reg_addr_t rs1s [20];
    logic [11:0]           imms [20];
    logic [11:0]           bits;
    begin_reset();
    for (int i = 0; i < 20; i++) begin
      take_bits(5, bits);
      rds[i] = bits[4:0];
      take_bits(5, bits);
      rs1s[i] = bits[4:0];
      take_bits(12, imms[i]);
      rom[i] = enc_i(rv_isa_pkg::maj_op_imm, rds[i], rs1s[i], imms[i]);
    end
    end_reset();
    for (int i = 0; i < 20; i++) begin
      check_data("pc", pc, `RV_RESET_PC + 64'(4 * i));
      check_addi(rds[i], rs1s[i], imms[i]);
      step();
    end
  endtask

  task automatic test_illegal();
    begin_reset();
    rom[0] = enc_i(rv_isa_pkg::maj_op_imm, 5'd10, 5'd0, 12'h009);
    // register-register add is not supported
    rom[1] = 32'h0000_0033;
    end_reset();
    check_addi(5'd10, 5'd0, 12'h009);
    step();
    check_bit("retire_valid", retire_valid, 1'b0);
    check_bit("halted", halted, 1'b0);
    step();
    check_bit("halted", halted, 1'b1);
    check_bit("illegal", illegal, 1'b1);
    check_data("pc", pc, `RV_RESET_PC + 64'd4);
    begin_reset();
    end_reset();
    check_bit("halted", halted, 1'b0);
    check_bit("illegal", illegal, 1'b0);
    check_data("pc", pc, `RV_RESET_PC);
  endtask

  initial begin
    #((test_cycles + 20) * clk_period);
    $display("Timeout: the tests did not finish within %0d cycles", test_cycles + 20);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset = 1'b1;
    lfsr = 16'd13415;
    test_lui_addi();
    test_auipc_jal();
    test_jalr();
    ebreak_run(12'h000);
    ebreak_run(12'hffd);
    test_random_addi();
    test_illegal();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core.sv
tb/rv_core_assertions.sv
tb/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation ended with an error status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
else
  exit 1
fi
